/* project.f */
+incdir+src
src/oq_pkg.sv
src/oq_classify.sv
src/oq_admit.sv
src/oq_cell_fifo.sv
src/oq_drop_counters.sv
src/output_queues_regs.sv
src/output_queues.sv
sim/tb_output_queues.sv

/* Makefile */
TOP = tb_output_queues

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f project.f \
		--top-module $(TOP) -Mdir obj_dir -o sim_$(TOP)

run: compile
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "TEST OK" sim.log

clean:
	rm -rf obj_dir sim.log

/* sim/tb_output_queues.sv */
`timescale 1ns/1ps
`include "oq_macros.svh"

module tb_output_queues
   import oq_pkg::*;
();

   localparam int LIMIT = 200;   // Cycles allowed per wait.

   logic                      ACLK;
   logic                      ARESETN;
   oq_cell_t                  in_cell;
   logic                      in_valid;
   logic                      deq;
   logic [2:0]                deq_queue;
   logic                      out_valid;
   logic [31:0]               out_data;
   logic [`OQ_NUM_QUEUES-1:0] queue_empty;
   logic [`OQ_NUM_QUEUES-1:0] queue_full;
   logic [31:0]               AWADDR;
   logic                      AWVALID;
   logic                      AWREADY;
   logic [31:0]               WDATA;
   logic [3:0]                WSTRB;
   logic                      WVALID;
   logic                      WREADY;
   logic [1:0]                BRESP;
   logic                      BVALID;
   logic                      BREADY;
   logic [31:0]               ARADDR;
   logic                      ARVALID;
   logic                      ARREADY;
   logic [31:0]               RDATA;
   logic [1:0]                RRESP;
   logic                      RVALID;
   logic                      RREADY;

   int          errors;
   int          checks;
   logic [31:0] rng;
   logic [31:0] model_q [`OQ_NUM_QUEUES][$];   // Cells stored or in flight.
   logic [31:0] model_drops [`OQ_NUM_QUEUES];
   int          model_qnum;
   logic        model_clear;

   output_queues dut (.*);

   always #2 ACLK = ~ACLK;

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   task automatic fail_value(input string test, input string what,
                             input logic [31:0] exp, input logic [31:0] act);
      errors++;
      $display("Fail %s: %s expected %h actual %h", test, what, exp, act);
   endtask

   task automatic abort_on_timeout(input string what);
      $display("Timeout while waiting for %s, stopping the run", what);
      $display("Checks: %0d, errors: %0d", checks, errors + 1);
      $display("TEST FAILED");
      $finish;
   endtask

   task automatic axi_write(input logic [31:0] addr, input logic [31:0] data,
                            output logic [1:0] resp);
      int t;
      AWADDR = addr;
      AWVALID = 1'b1;
      t = 0;
      while (!AWREADY && t < LIMIT) begin
         @(posedge ACLK);
         #1;
         t++;
      end
      if (!AWREADY) abort_on_timeout("AWREADY");
      @(posedge ACLK);
      #1;
      AWVALID = 1'b0;
      WDATA = data;
      WSTRB = 4'hf;
      WVALID = 1'b1;
      t = 0;
      while (!WREADY && t < LIMIT) begin
         @(posedge ACLK);
         #1;
         t++;
      end
      if (!WREADY) abort_on_timeout("WREADY");
      @(posedge ACLK);
      #1;
      WVALID = 1'b0;
      BREADY = 1'b1;
      t = 0;
      while (!BVALID && t < LIMIT) begin
         @(posedge ACLK);
         #1;
         t++;
      end
      if (!BVALID) abort_on_timeout("BVALID");
      resp = BRESP;
      @(posedge ACLK);
      #1;
      BREADY = 1'b0;
   endtask

   task automatic axi_read(input logic [31:0] addr, output logic [31:0] data,
                           output logic [1:0] resp);
      int t;
      ARADDR = addr;
      ARVALID = 1'b1;
      t = 0;
      while (!ARREADY && t < LIMIT) begin
         @(posedge ACLK);
         #1;
         t++;
      end
      if (!ARREADY) abort_on_timeout("ARREADY");
      @(posedge ACLK);
      #1;
      ARVALID = 1'b0;
      t = 0;
      while (!RVALID && t < LIMIT) begin
         @(posedge ACLK);
         #1;
         t++;
      end
      if (!RVALID) abort_on_timeout("RVALID");
      data = RDATA;
      resp = RRESP;
      @(posedge ACLK);   // One stall cycle, response must hold.
      #1;
      checks++;
      if (!RVALID || RDATA !== data || RRESP !== resp) begin
         errors++;
         $display("Read response at %h did not hold while RREADY was low", addr);
      end
      RREADY = 1'b1;
      @(posedge ACLK);
      #1;
      RREADY = 1'b0;
   endtask

   task automatic set_reg(input string test, input logic [31:0] addr,
                          input logic [31:0] data);
      logic [1:0] resp;
      axi_write(addr, data, resp);
      checks++;
      if (resp !== AXI_RESP_OK) fail_value(test, "BRESP", AXI_RESP_OK, resp);
   endtask

   task automatic expect_reg(input string test, input logic [31:0] addr,
                             input logic [31:0] exp);
      logic [31:0] data;
      logic [1:0]  resp;
      axi_read(addr, data, resp);
      checks += 2;
      if (resp !== AXI_RESP_OK) fail_value(test, "RRESP", AXI_RESP_OK, resp);
      if (data !== exp) fail_value(test, $sformatf("register %h", addr), exp, data);
   endtask

   // Accept when enabled and there is room, else a drop on a real queue.
   function automatic void predict_cell(input int dest, input logic [31:0] data);
      if (dest < `OQ_NUM_QUEUES && dest < model_qnum && model_q[dest].size() < `OQ_DEPTH) begin
         model_q[dest].push_back(data);
      end else if (dest < `OQ_NUM_QUEUES && !model_clear) begin
         model_drops[dest]++;
      end
   endfunction

   task automatic send_cell(input int dest, input logic [31:0] data);
      predict_cell(dest, data);
      in_cell.dest = 3'(dest);
      in_cell.data = data;
      in_valid = 1'b1;
      @(posedge ACLK);
      #1;
      in_valid = 1'b0;
   endtask

   task automatic pop_cell(input string test, input int q);
      logic [31:0] exp;
      int          t;
      t = 0;
      while (queue_empty[q] && t < LIMIT) begin   // Cell may still be in flight.
         @(posedge ACLK);
         #1;
         t++;
      end
      if (queue_empty[q]) abort_on_timeout($sformatf("a cell in queue %0d", q));
      deq = 1'b1;
      deq_queue = 3'(q);
      @(posedge ACLK);
      #1;
      deq = 1'b0;
      exp = model_q[q].pop_front();
      checks++;
      if (!out_valid) begin
         errors++;
         $display("Fail %s: no out_valid after a deq of queue %0d", test, q);
      end else if (out_data !== exp) begin
         fail_value(test, $sformatf("queue %0d out_data", q), exp, out_data);
      end
   endtask

   // FIFO and counters see a cell three edges after in_valid.
   task automatic drain_pipeline();
      repeat (3) begin
         @(posedge ACLK);
         #1;
      end
   endtask

   task automatic check_counts(input string test);
      for (int i = 0; i < `OQ_NUM_QUEUES; i++) begin
         expect_reg(test, 32'(`OQ_REG_DROP_BASE) + 32'(i), model_drops[i]);
      end
   endtask

   task automatic register_access();
      logic [31:0] data;
      logic [1:0]  resp;
      expect_reg("registers", `OQ_REG_QUEUES_NUM, 32'd5);
      expect_reg("registers", `OQ_REG_RESET_DROP, 32'd0);
      set_reg("registers", `OQ_REG_QUEUES_NUM, 32'd3);
      expect_reg("registers", `OQ_REG_QUEUES_NUM, 32'd3);
      set_reg("registers", `OQ_REG_RESET_DROP, 32'd1);
      expect_reg("registers", `OQ_REG_RESET_DROP, 32'd1);
      set_reg("registers", `OQ_REG_RESET_DROP, 32'd0);
      expect_reg("registers", `OQ_REG_RESET_DROP, 32'd0);
      set_reg("registers", `OQ_REG_QUEUES_NUM, 32'd5);
      expect_reg("registers", `OQ_REG_QUEUES_NUM, 32'd5);
      axi_write(32'h20, 32'h1234_5678, resp);
      checks++;
      if (resp !== AXI_RESP_SLVERR) begin
         fail_value("registers", "BRESP at 0x20", AXI_RESP_SLVERR, resp);
      end
      axi_read(32'h20, data, resp);
      checks++;
      if (resp !== AXI_RESP_SLVERR) begin
         fail_value("registers", "RRESP at 0x20", AXI_RESP_SLVERR, resp);
      end
   endtask

   task automatic cell_ordering();
      for (int i = 0; i < 3; i++) begin
         for (int q = 0; q < `OQ_NUM_QUEUES; q++) begin
            send_cell(q, 32'ha000_0000 + 32'(q << 8) + 32'(i));
         end
      end
      drain_pipeline();
      for (int q = 0; q < `OQ_NUM_QUEUES; q++) begin
         while (model_q[q].size() > 0) pop_cell("ordering", q);
      end
      checks++;
      if (queue_empty !== '1) fail_value("ordering", "queue_empty", 32'h1f, queue_empty);
   endtask

   task automatic queue_overflow();
      for (int i = 0; i < `OQ_DEPTH + 3; i++) begin
         send_cell(2, 32'hb000_0000 + 32'(i));   // Back to back, no pops.
      end
      drain_pipeline();
      checks++;
      if (queue_full[2] !== 1'b1) fail_value("overflow", "queue_full[2]", 1, queue_full[2]);
      check_counts("overflow");
      while (model_q[2].size() > 0) pop_cell("overflow", 2);
      checks++;
      if (queue_empty[2] !== 1'b1) fail_value("overflow", "queue_empty[2]", 1, queue_empty[2]);
   endtask

   task automatic disabled_queues();
      set_reg("disabled", `OQ_REG_QUEUES_NUM, 32'd3);
      model_qnum = 3;
      for (int q = 0; q < `OQ_NUM_QUEUES; q++) begin
         send_cell(q, 32'hc000_0000 + 32'(q));
      end
      send_cell(6, 32'hc000_0006);   // No such queue.
      drain_pipeline();
      check_counts("disabled");
      checks++;
      if (queue_empty[4:3] !== 2'b11) begin
         fail_value("disabled", "queue_empty[4:3]", 3, queue_empty[4:3]);
      end
      for (int q = 0; q < 3; q++) begin
         while (model_q[q].size() > 0) pop_cell("disabled", q);
      end
      set_reg("disabled", `OQ_REG_QUEUES_NUM, 32'd5);
      model_qnum = 5;
   endtask

   task automatic count_clearing();
      set_reg("clear", `OQ_REG_RESET_DROP, 32'd1);
      model_clear = 1'b1;
      foreach (model_drops[i]) model_drops[i] = '0;
      check_counts("clear");
      for (int i = 0; i < `OQ_DEPTH + 2; i++) begin
         send_cell(1, 32'hd000_0000 + 32'(i));
      end
      drain_pipeline();
      check_counts("clear");
      set_reg("clear", `OQ_REG_RESET_DROP, 32'd0);
      model_clear = 1'b0;
      for (int i = 0; i < 2; i++) begin
         send_cell(1, 32'hd100_0000 + 32'(i));   // Queue 1 is still full.
      end
      drain_pipeline();
      check_counts("clear");
      while (model_q[1].size() > 0) pop_cell("clear", 1);
   endtask

   task automatic random_traffic();
      int dest;
      int q;
      for (int n = 0; n < 60; n++) begin
         rng = xorshift32(rng);
         dest = int'(rng % 32'd5);
         if (model_q[dest].size() < `OQ_DEPTH - 1) send_cell(dest, rng ^ 32'h5a5a_0000);
         q = int'(rng[15:8] % 8'd5);
         if (rng[16] && model_q[q].size() > 0) pop_cell("random", q);
      end
      for (int i = 0; i < `OQ_NUM_QUEUES; i++) begin
         while (model_q[i].size() > 0) pop_cell("random", i);
      end
      checks++;
      if (queue_empty !== '1) fail_value("random", "queue_empty", 32'h1f, queue_empty);
   endtask

   initial begin
      ACLK = 1'b0;
      ARESETN = 1'b0;
      in_cell = '0;
      in_valid = 1'b0;
      deq = 1'b0;
      deq_queue = '0;
      AWADDR = '0;
      AWVALID = 1'b0;
      WDATA = '0;
      WSTRB = '0;
      WVALID = 1'b0;
      BREADY = 1'b0;
      ARADDR = '0;
      ARVALID = 1'b0;
      RREADY = 1'b0;
      errors = 0;
      checks = 0;
      rng = 32'd14525;
      model_qnum = 5;
      model_clear = 1'b0;
      foreach (model_drops[i]) model_drops[i] = '0;
      repeat (3) @(posedge ACLK);
      #1;
      ARESETN = 1'b1;
      @(posedge ACLK);
      #1;
      register_access();
      cell_ordering();
      queue_overflow();
      disabled_queues();
      count_clearing();
      random_traffic();
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

/* src/output_queues.sv */
`timescale 1ns/1ps
`include "oq_macros.svh"

module output_queues
   import oq_pkg::*;
(
   input  logic                      ACLK,
   input  logic                      ARESETN,

   input  oq_cell_t                  in_cell,
   input  logic                      in_valid,
   input  logic                      deq,
   input  logic [2:0]                deq_queue,
   output logic                      out_valid,
   output logic [31:0]               out_data,
   output logic [`OQ_NUM_QUEUES-1:0] queue_empty,
   output logic [`OQ_NUM_QUEUES-1:0] queue_full,

   input  logic [31:0]               AWADDR,
   input  logic                      AWVALID,
   output logic                      AWREADY,
   input  logic [31:0]               WDATA,
   input  logic [3:0]                WSTRB,
   input  logic                      WVALID,
   output logic                      WREADY,
   output logic [1:0]                BRESP,
   output logic                      BVALID,
   input  logic                      BREADY,
   input  logic [31:0]               ARADDR,
   input  logic                      ARVALID,
   output logic                      ARREADY,
   output logic [31:0]               RDATA,
   output logic [1:0]                RRESP,
   output logic                      RVALID,
   input  logic                      RREADY
);

   oq_slot_t                           slot;
   oq_enq_t                            enq;
   logic [31:0]                        queues_num;
   logic                               reset_drop_counts;
   logic [`OQ_NUM_QUEUES-1:0]          q_almost_full;
   logic [`OQ_NUM_QUEUES-1:0]          q_rd;
   logic [`OQ_NUM_QUEUES-1:0]          q_rd_valid;
   logic [`OQ_NUM_QUEUES-1:0][31:0]    q_rd_data;
   logic [`OQ_NUM_QUEUES-1:0][31:0]    drop_counts;

   oq_classify u_classify (
      .ACLK(ACLK), .ARESETN(ARESETN), .in_cell(in_cell), .in_valid(in_valid),
      .queues_num(queues_num), .slot(slot)
   );

   oq_admit u_admit (
      .ACLK(ACLK), .ARESETN(ARESETN), .slot(slot), .full(queue_full),
      .almost_full(q_almost_full), .enq(enq)
   );

   for (genvar i = 0; i < `OQ_NUM_QUEUES; i++) begin : g_queue
      assign q_rd[i] = deq && (deq_queue == 3'(i)) && !queue_empty[i];   // No pop when empty.

      oq_cell_fifo u_fifo (
         .ACLK(ACLK), .ARESETN(ARESETN),
         .wr(enq.enq && (enq.queue == 3'(i))), .wr_data(enq.data), .rd(q_rd[i]),
         .rd_data(q_rd_data[i]), .rd_valid(q_rd_valid[i]), .empty(queue_empty[i]),
         .full(queue_full[i]), .almost_full(q_almost_full[i])
      );
   end

   // At most one FIFO answers per cycle.
   always_comb begin
      out_data = '0;
      for (int i = 0; i < `OQ_NUM_QUEUES; i++) begin
         if (q_rd_valid[i]) begin
            out_data = q_rd_data[i];
         end
      end
   end

   assign out_valid = |q_rd_valid;

   oq_drop_counters u_drops (
      .ACLK(ACLK), .ARESETN(ARESETN), .enq(enq), .clear(reset_drop_counts),
      .drop_counts(drop_counts)
   );

   output_queues_regs u_regs (
      .ACLK(ACLK), .ARESETN(ARESETN), .drop_counts(drop_counts),
      .queues_num(queues_num), .reset_drop_counts(reset_drop_counts),
      .AWADDR(AWADDR), .AWVALID(AWVALID), .AWREADY(AWREADY),
      .WDATA(WDATA), .WSTRB(WSTRB), .WVALID(WVALID), .WREADY(WREADY),
      .BRESP(BRESP), .BVALID(BVALID), .BREADY(BREADY),
      .ARADDR(ARADDR), .ARVALID(ARVALID), .ARREADY(ARREADY),
      .RDATA(RDATA), .RRESP(RRESP), .RVALID(RVALID), .RREADY(RREADY)
   );

endmodule

/* src/output_queues_regs.sv */
`timescale 1ns/1ps
`include "oq_macros.svh"

module output_queues_regs
   import oq_pkg::*;
#(
   parameter int ADDR_WIDTH = 32,
   parameter int DATA_WIDTH = 32
) (
   input  logic                              ACLK,
   input  logic                              ARESETN,

   input  logic [`OQ_NUM_QUEUES-1:0][31:0]   drop_counts,
   output logic [31:0]                       queues_num,
   output logic                              reset_drop_counts,

   input  logic [ADDR_WIDTH-1:0]             AWADDR,
   input  logic                              AWVALID,
   output logic                              AWREADY,

   input  logic [DATA_WIDTH-1:0]             WDATA,
   input  logic [DATA_WIDTH/8-1:0]           WSTRB,
   input  logic                              WVALID,
   output logic                              WREADY,

   output logic [1:0]                        BRESP,
   output logic                              BVALID,
   input  logic                              BREADY,

   input  logic [ADDR_WIDTH-1:0]             ARADDR,
   input  logic                              ARVALID,
   output logic                              ARREADY,

   output logic [DATA_WIDTH-1:0]             RDATA,
   output logic [1:0]                        RRESP,
   output logic                              RVALID,
   input  logic                              RREADY
);

   typedef enum logic [1:0] {
      WR_IDLE,
      WR_DATA,
      WR_RESP
   } wr_state_t;

   typedef enum logic {
      RD_IDLE,
      RD_RESP
   } rd_state_t;

   wr_state_t             wr_state;
   rd_state_t             rd_state;
   logic [7:0]            wr_offset;
   logic [7:0]            drop_idx;
   logic [DATA_WIDTH-1:0] rd_word;
   logic [1:0]            rd_code;

   assign AWREADY = (wr_state == WR_IDLE);
   assign WREADY = (wr_state == WR_DATA);
   assign BVALID = (wr_state == WR_RESP);
   assign ARREADY = (rd_state == RD_IDLE);
   assign RVALID = (rd_state == RD_RESP);

   // Write side.
   always_ff @(posedge ACLK) begin
      if (!ARESETN) begin
         wr_state <= WR_IDLE;
         BRESP <= AXI_RESP_OK;
         queues_num <= `OQ_QUEUES_NUM_RESET;
         reset_drop_counts <= 1'b0;
      end else begin
         case (wr_state)
            WR_IDLE: begin
               if (AWVALID) begin
                  wr_offset <= AWADDR[7:0];
                  wr_state <= WR_DATA;
               end
            end
            WR_DATA: begin
               if (WVALID) begin
                  BRESP <= AXI_RESP_OK;
                  if (wr_offset == `OQ_REG_QUEUES_NUM) begin
                     for (int b = 0; b < 4; b++) begin
                        if (WSTRB[b]) begin
                           queues_num[8*b +: 8] <= WDATA[8*b +: 8];   // Byte lanes.
                        end
                     end
                  end else if (wr_offset == `OQ_REG_RESET_DROP) begin
                     if (WSTRB[0]) begin
                        reset_drop_counts <= WDATA[0];
                     end
                  end else begin
                     BRESP <= AXI_RESP_SLVERR;   // Counters are read-only.
                  end
                  wr_state <= WR_RESP;
               end
            end
            WR_RESP: begin
               if (BREADY) begin
                  wr_state <= WR_IDLE;
               end
            end
            default: wr_state <= WR_IDLE;
         endcase
      end
   end

   // Read decode on the incoming address.
   assign drop_idx = ARADDR[7:0] - `OQ_REG_DROP_BASE;

   always_comb begin
      rd_word = '0;
      rd_code = AXI_RESP_OK;
      if (ARADDR[7:0] == `OQ_REG_QUEUES_NUM) begin
         rd_word = queues_num;
      end else if (ARADDR[7:0] == `OQ_REG_RESET_DROP) begin
         rd_word[0] = reset_drop_counts;
      end else if (drop_idx < 8'(`OQ_NUM_QUEUES)) begin
         for (int i = 0; i < `OQ_NUM_QUEUES; i++) begin
            if (drop_idx == 8'(i)) begin
               rd_word = drop_counts[i];
            end
         end
      end else begin
         rd_code = AXI_RESP_SLVERR;
      end
   end

   // Read side, data captured at AR so it holds until RREADY.
   always_ff @(posedge ACLK) begin
      if (!ARESETN) begin
         rd_state <= RD_IDLE;
      end else begin
         case (rd_state)
            RD_IDLE: begin
               if (ARVALID) begin
                  RDATA <= rd_word;
                  RRESP <= rd_code;
                  rd_state <= RD_RESP;
               end
            end
            RD_RESP: begin
               if (RREADY) begin
                  rd_state <= RD_IDLE;
               end
            end
            default: rd_state <= RD_IDLE;
         endcase
      end
   end

   assert property (@(posedge ACLK) disable iff (!ARESETN)
      RVALID && !RREADY |=> RVALID && $stable(RDATA) && $stable(RRESP));

endmodule

/* src/oq_drop_counters.sv */
`timescale 1ns/1ps
`include "oq_macros.svh"

module oq_drop_counters
   import oq_pkg::*;
(
   input  logic                                ACLK,
   input  logic                                ARESETN,
   input  oq_enq_t                             enq,
   input  logic                                clear,
   output logic [`OQ_NUM_QUEUES-1:0][31:0]     drop_counts
);

   logic counted;

   assign counted = enq.drop && enq.count;

   always_ff @(posedge ACLK) begin
      if (!ARESETN) begin
         drop_counts <= '0;
      end else if (clear) begin
         drop_counts <= '0;   // Held at zero while set.
      end else begin
         for (int i = 0; i < `OQ_NUM_QUEUES; i++) begin
            if (counted && (enq.queue == 3'(i))) begin
               drop_counts[i] <= drop_counts[i] + 32'd1;
            end
         end
      end
   end

endmodule

/* src/oq_cell_fifo.sv */
`timescale 1ns/1ps
`include "oq_macros.svh"

module oq_cell_fifo (
   input  logic        ACLK,
   input  logic        ARESETN,
   input  logic        wr,
   input  logic [31:0] wr_data,
   input  logic        rd,
   output logic [31:0] rd_data,
   output logic        rd_valid,
   output logic        empty,
   output logic        full,
   output logic        almost_full
);

   localparam int PTR_W = $clog2(`OQ_DEPTH);
   localparam logic [PTR_W:0] FULL_CNT = `OQ_DEPTH;
   localparam logic [PTR_W:0] ALMOST_CNT = `OQ_DEPTH - 1;

   logic [31:0]      mem [`OQ_DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [PTR_W:0]   count;

   always_ff @(posedge ACLK) begin
      if (wr) begin
         mem[wr_ptr] <= wr_data;
      end
      if (rd) begin
         rd_data <= mem[rd_ptr];   // Registered read port.
      end
   end

   always_ff @(posedge ACLK) begin
      if (!ARESETN) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count <= '0;
         rd_valid <= 1'b0;
      end else begin
         rd_valid <= rd;
         if (wr) begin
            wr_ptr <= wr_ptr + 1'b1;   // Depth is a power of two.
         end
         if (rd) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({wr, rd})
            2'b10: count <= count + 1'b1;
            2'b01: count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   assign empty = (count == '0);
   assign full = (count == FULL_CNT);
   assign almost_full = (count == ALMOST_CNT);

   // Admission and the deq gate upstream must keep these.
   assert property (@(posedge ACLK) disable iff (!ARESETN) wr |-> !full);
   assert property (@(posedge ACLK) disable iff (!ARESETN) rd |-> !empty);

endmodule

/* src/oq_admit.sv */
`timescale 1ns/1ps
`include "oq_macros.svh"

module oq_admit
   import oq_pkg::*;
(
   input  logic                      ACLK,
   input  logic                      ARESETN,
   input  oq_slot_t                  slot,
   input  logic [`OQ_NUM_QUEUES-1:0] full,
   input  logic [`OQ_NUM_QUEUES-1:0] almost_full,
   output oq_enq_t                   enq
);

   logic [7:0] full_x;
   logic [7:0] almost_full_x;
   logic       in_flight;
   logic       accept;

   // Widen so queue numbers 5..7 index a zero bit.
   assign full_x = 8'(full);
   assign almost_full_x = 8'(almost_full);

   // Previous enq is still on its way into this FIFO.
   assign in_flight = enq.enq && (enq.queue == slot.queue);

   assign accept = slot.valid && slot.enabled && !full_x[slot.queue] &&
                   !(almost_full_x[slot.queue] && in_flight);

   always_ff @(posedge ACLK) begin
      if (!ARESETN) begin
         enq.enq <= 1'b0;
         enq.drop <= 1'b0;
         enq.count <= 1'b0;
      end else begin
         enq.enq <= accept;
         enq.drop <= slot.valid && !accept;
         enq.count <= slot.valid && !accept && (32'(slot.queue) < `OQ_NUM_QUEUES);
         enq.queue <= slot.queue;
         enq.data <= slot.data;
      end
   end

   assert property (@(posedge ACLK) disable iff (!ARESETN)
      !(enq.enq && enq.drop));

endmodule

/* src/oq_classify.sv */
`timescale 1ns/1ps
`include "oq_macros.svh"

module oq_classify
   import oq_pkg::*;
(
   input  logic        ACLK,
   input  logic        ARESETN,
   input  oq_cell_t    in_cell,
   input  logic        in_valid,
   input  logic [31:0] queues_num,
   output oq_slot_t    slot
);

   logic dest_real;
   logic dest_on;

   assign dest_real = 32'(in_cell.dest) < `OQ_NUM_QUEUES;   // Dest 5..7 never exist.
   assign dest_on = 32'(in_cell.dest) < queues_num;

   always_ff @(posedge ACLK) begin
      if (!ARESETN) begin
         slot.valid <= 1'b0;
         slot.enabled <= 1'b0;
      end else begin
         slot.valid <= in_valid;
         slot.enabled <= dest_real && dest_on;
         slot.queue <= in_cell.dest;
         slot.data <= in_cell.data;
      end
   end

endmodule

/* src/oq_pkg.sv */
package oq_pkg;

   // Input cell, one word plus destination queue.
   typedef struct packed {
      logic [2:0]  dest;
      logic [31:0] data;
   } oq_cell_t;

   // Classify to admit.
   typedef struct packed {
      logic        valid;
      logic        enabled;
      logic [2:0]  queue;
      logic [31:0] data;
   } oq_slot_t;

   // Admit to FIFOs and drop counters.
   typedef struct packed {
      logic        enq;
      logic        drop;
      logic        count;   // Drop lands on a real queue.
      logic [2:0]  queue;
      logic [31:0] data;
   } oq_enq_t;

   localparam logic [1:0] AXI_RESP_OK = 2'b00;
   localparam logic [1:0] AXI_RESP_SLVERR = 2'b10;

endpackage

/* src/oq_macros.svh */
`ifndef OQ_MACROS_SVH
`define OQ_MACROS_SVH

// Queue geometry.
`define OQ_NUM_QUEUES 5
`define OQ_DEPTH 8

// Register map, decoded on the low address byte.
`define OQ_REG_QUEUES_NUM 8'h00
`define OQ_REG_RESET_DROP 8'h01
`define OQ_REG_DROP_BASE 8'h10

// All physical queues enabled out of reset.
`define OQ_QUEUES_NUM_RESET 32'd5

`endif
